// ==== hdl/readout_pkg.sv ====
//##################################################
// Readout core shared widths, word formats and
// trigger FSM state encoding
//##################################################
package readout_pkg;

    localparam int DATA_W    = 32;
    localparam int ID_W      = 4;
    localparam int PAYLOAD_W = DATA_W - ID_W;

    // Source id reserved for trigger number words
    localparam logic [ID_W-1:0] TRIG_ID = 4'd15;

    // Output word, id in the top nibble
    typedef struct packed {
        logic [ID_W-1:0]      src_id;
        logic [PAYLOAD_W-1:0] payload;
    } data_word_t;

    // Per channel state shown on the LEDs
    typedef struct packed {
        logic ready;     // Receiver locked
        logic overflow;  // Sticky, cleared by reset only
        logic full;
    } chan_status_t;

    typedef enum logic [1:0] {
        trig_idle,
        trig_wait_cmd,
        trig_wait_release
    } trig_state_e;

endpackage

// ==== hdl/trigger_fsm.sv ====
//##################################################
// Trigger FSM: source select, veto, command start
// handshake and trigger number counter
//##################################################
`timescale 1ns/1ns

module trigger_fsm (
    input  logic                            bus_clk,
    input  logic                            rst_n,
    input  logic                            trigger_rj45,
    input  logic                            trigger_lemo,
    input  logic                            rj45_enabled,
    input  logic                            ext_veto,
    input  logic                            cmd_ready,
    input  logic                            near_full,   // Trigger FIFO almost full
    output logic                            busy,
    output logic                            cmd_start,
    output logic                            push,
    output logic [readout_pkg::PAYLOAD_W-1:0] payload
);
    import readout_pkg::*;

    trig_state_e          state;
    logic                 trig_sel;
    logic                 trig_q;
    logic                 trig_prev;
    logic                 trig_edge;
    logic                 accept;
    logic                 fire;
    logic [PAYLOAD_W-1:0] trig_num;

    assign trig_sel  = rj45_enabled ? trigger_rj45 : trigger_lemo;
    assign trig_edge = trig_q & ~trig_prev;
    assign accept    = trig_edge & ~ext_veto & ~near_full;
    assign fire      = (state == trig_wait_cmd) & cmd_ready;  // Sequencer free

    // Busy for the whole handshake, drops on return to idle
    assign busy = (state != trig_idle);

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            state     <= trig_idle;
            trig_q    <= 1'b0;
            trig_prev <= 1'b0;
            cmd_start <= 1'b0;
            push      <= 1'b0;
            trig_num  <= '0;
        end else begin
            trig_q    <= trig_sel;
            trig_prev <= trig_q;
            cmd_start <= 1'b0;
            push      <= 1'b0;
            case (state)
                trig_idle: begin
                    if (accept)
                        state <= trig_wait_cmd;
                end
                trig_wait_cmd: begin
                    if (fire) begin
                        cmd_start <= 1'b1;
                        push      <= 1'b1;  // One trigger word per cmd_start
                        trig_num  <= trig_num + 1'b1;
                        state     <= trig_wait_release;
                    end
                end
                trig_wait_release: begin
                    // Hold busy until the trigger input goes away
                    if (!trig_q)
                        state <= trig_idle;
                end
                default: state <= trig_idle;
            endcase
        end
    end

    always_ff @(posedge bus_clk) begin
        if (fire)
            payload <= trig_num;
    end

endmodule

// ==== hdl/blink_timer.sv ====
//##################################################
// Blink divider and version display window
//##################################################
`timescale 1ns/1ns

module blink_timer #(
    parameter int BLINK_DIV      = 12_500_000,
    parameter int VERSION_CYCLES = 100_000_000
) (
    input  logic bus_clk,
    input  logic rst_n,
    output logic blink_slow,
    output logic blink_fast,
    output logic version_window
);
    localparam int HALF  = (BLINK_DIV / 2 > 0) ? BLINK_DIV / 2 : 1;
    localparam int DIV_W = $clog2(HALF + 1);
    localparam int VER_W = $clog2(VERSION_CYCLES + 1);

    logic [DIV_W-1:0] div_cnt;
    logic [VER_W-1:0] ver_cnt;

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            div_cnt    <= '0;
            blink_fast <= 1'b0;
            blink_slow <= 1'b0;
            ver_cnt    <= '0;
        end else begin
            if (div_cnt == DIV_W'(HALF - 1)) begin
                div_cnt    <= '0;
                blink_fast <= ~blink_fast;
                if (blink_fast)
                    blink_slow <= ~blink_slow;  // Every second fast toggle
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (ver_cnt != VER_W'(VERSION_CYCLES))
                ver_cnt <= ver_cnt + 1'b1;  // Saturates at end of window
        end
    end

    assign version_window = (ver_cnt != VER_W'(VERSION_CYCLES));

endmodule

// ==== hdl/channel_fifo.sv ====
//##################################################
// Channel word FIFO, tags payloads with source id
//##################################################
`timescale 1ns/1ns

module channel_fifo #(
    parameter int                           FIFO_DEPTH = 8,
    parameter logic [readout_pkg::ID_W-1:0] SRC_ID     = '0
) (
    input  logic                              bus_clk,
    input  logic                              rst_n,
    input  logic                              push,
    input  logic                              pop,
    input  logic [readout_pkg::PAYLOAD_W-1:0] payload,
    input  logic                              locked,   // Goes to status.ready
    output readout_pkg::data_word_t           head,
    output logic                              empty,
    output logic                              near_full,
    output readout_pkg::chan_status_t         status
);
    import readout_pkg::*;

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    logic [PAYLOAD_W-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]        wr_ptr;
    logic [AW-1:0]        rd_ptr;
    logic [CW-1:0]        count;
    logic                 full;
    logic                 overflow;
    logic                 wr_en;
    logic                 rd_en;

    assign full      = (count == CW'(FIFO_DEPTH));
    assign empty     = (count == '0);
    assign near_full = (count >= CW'(FIFO_DEPTH - 1));
    assign wr_en     = push & ~full;   // Writes to a full FIFO are lost
    assign rd_en     = pop & ~empty;

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en)
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (wr_en && !rd_en)
                count <= count + 1'b1;
            else if (rd_en && !wr_en)
                count <= count - 1'b1;
            if (push && full)
                overflow <= 1'b1;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (wr_en)
            mem[wr_ptr] <= payload;
    end

    assign head.src_id  = SRC_ID;
    assign head.payload = mem[rd_ptr];

    assign status.ready    = locked;
    assign status.overflow = overflow;
    assign status.full     = full;

endmodule

// ==== hdl/priority_arbiter.sv ====
//##################################################
// Round-robin arbiter, last source has priority,
// registered output word stage
//##################################################
`timescale 1ns/1ns

module priority_arbiter #(
    parameter int NUM_SRC = 5
) (
    input  logic                    bus_clk,
    input  logic                    rst_n,
    input  logic                    out_ready,
    input  logic                    hold_req,          // Priority source wants out
    input  logic [NUM_SRC-1:0]      empty,
    input  readout_pkg::data_word_t words [NUM_SRC],
    output logic [NUM_SRC-1:0]      pop,
    output logic                    out_write,
    output readout_pkg::data_word_t out_word
);
    localparam int NUM_RR = NUM_SRC - 1;   // Rotating sources, priority one excluded
    localparam int SEL_W  = $clog2(NUM_SRC);

    logic [SEL_W-1:0] last_rx;
    logic [SEL_W-1:0] gnt;
    logic             take;

    assign take = out_ready & ~&empty;

    // Search starts one past the last granted rx channel
    always_comb begin
        int   idx;
        logic found;
        found = 1'b0;
        gnt   = last_rx;
        for (int k = 1; k <= NUM_RR; k++) begin
            idx = int'(last_rx) + k;
            if (idx >= NUM_RR)
                idx = idx - NUM_RR;
            if (!found && !empty[idx]) begin
                gnt   = SEL_W'(idx);
                found = 1'b1;
            end
        end
        if (hold_req)
            gnt = SEL_W'(NUM_SRC - 1);
    end

    always_comb begin
        pop = '0;
        if (take)
            pop[gnt] = 1'b1;  // Head leaves the FIFO this cycle
    end

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            out_write <= 1'b0;
            last_rx   <= SEL_W'(NUM_RR - 1);
        end else begin
            out_write <= take;
            // Priority grants leave the rotation alone
            if (take && !hold_req)
                last_rx <= gnt;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (take)
            out_word <= words[gnt];
    end

endmodule

// ==== hdl/led_status.sv ====
//##################################################
// LED driver: version number, trigger and channels
//##################################################
`timescale 1ns/1ns

module led_status #(
    parameter int              NUM_RX  = 4,
    parameter logic [NUM_RX:0] VERSION = 3
) (
    input  logic                      blink_slow,
    input  logic                      blink_fast,
    input  logic                      version_window,
    input  logic                      rj45_enabled,
    input  logic                      trigger_busy,
    input  readout_pkg::chan_status_t chan [NUM_RX],
    output logic [NUM_RX:0]           led
);
    logic [NUM_RX:0] state_led;

    // Trigger LED: blink rate tells the selected input
    assign state_led[0] = trigger_busy | (rj45_enabled ? blink_fast : blink_slow);

    for (genvar i = 0; i < NUM_RX; i++) begin : g_chan
        // Dark until locked, solid on any FIFO trouble
        assign state_led[i+1] = chan[i].ready &
                                (blink_slow | chan[i].overflow | chan[i].full);
    end

    assign led = version_window ? VERSION : state_led;

endmodule

// ==== hdl/readout_top.sv ====
//##################################################
// Readout core top: trigger, channel FIFOs, arbiter
//##################################################
`timescale 1ns/1ns

module readout_top #(
    parameter int              NUM_RX         = 4,
    parameter int              FIFO_DEPTH     = 8,
    parameter int              BLINK_DIV      = 12_500_000,  // 1 Hz at 25 MHz
    parameter int              VERSION_CYCLES = 100_000_000,
    parameter logic [NUM_RX:0] VERSION        = 3
) (
    input  logic                              bus_clk,
    input  logic                              rst_n,
    input  logic                              trigger_rj45,
    input  logic                              trigger_lemo,
    input  logic                              rj45_enabled,
    input  logic                              ext_veto,
    input  logic                              cmd_ready,
    input  logic [NUM_RX-1:0]                 rx_valid,
    input  logic [readout_pkg::PAYLOAD_W-1:0] rx_payload [NUM_RX],
    input  logic [NUM_RX-1:0]                 rx_locked,
    input  logic                              out_ready,
    output logic                              trigger_busy,
    output logic                              cmd_start,
    output logic                              out_write,
    output readout_pkg::data_word_t           out_word,
    output logic [NUM_RX:0]                   led
);
    import readout_pkg::*;

    localparam int NUM_SRC = NUM_RX + 1;   // Trigger FIFO sits at index NUM_RX

    logic                 trig_push;
    logic [PAYLOAD_W-1:0] trig_payload;
    logic                 trig_near_full;
    logic [NUM_SRC-1:0]   fifo_empty;
    logic [NUM_SRC-1:0]   fifo_pop;
    data_word_t           fifo_head [NUM_SRC];
    chan_status_t         chan_stat [NUM_RX];
    logic                 blink_slow;
    logic                 blink_fast;
    logic                 version_window;

    trigger_fsm i_trigger_fsm (
        .bus_clk, .rst_n, .trigger_rj45, .trigger_lemo, .rj45_enabled, .ext_veto,
        .cmd_ready, .near_full(trig_near_full), .busy(trigger_busy), .cmd_start,
        .push(trig_push), .payload(trig_payload)
    );

    for (genvar i = 0; i < NUM_RX; i++) begin : g_rx
        channel_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .SRC_ID(ID_W'(i + 1))) i_fifo (
            .bus_clk, .rst_n, .push(rx_valid[i]), .pop(fifo_pop[i]),
            .payload(rx_payload[i]), .locked(rx_locked[i]), .head(fifo_head[i]),
            .empty(fifo_empty[i]), .near_full(), .status(chan_stat[i])
        );
    end

    channel_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .SRC_ID(TRIG_ID)) i_trig_fifo (
        .bus_clk, .rst_n, .push(trig_push), .pop(fifo_pop[NUM_RX]),
        .payload(trig_payload), .locked(1'b1), .head(fifo_head[NUM_RX]),
        .empty(fifo_empty[NUM_RX]), .near_full(trig_near_full), .status()
    );

    priority_arbiter #(.NUM_SRC(NUM_SRC)) i_arbiter (
        .bus_clk, .rst_n, .out_ready, .hold_req(~fifo_empty[NUM_RX]),
        .empty(fifo_empty), .words(fifo_head), .pop(fifo_pop), .out_write, .out_word
    );

    blink_timer #(.BLINK_DIV(BLINK_DIV), .VERSION_CYCLES(VERSION_CYCLES)) i_blink (
        .bus_clk, .rst_n, .blink_slow, .blink_fast, .version_window
    );

    led_status #(.NUM_RX(NUM_RX), .VERSION(VERSION)) i_led (
        .blink_slow, .blink_fast, .version_window, .rj45_enabled, .trigger_busy,
        .chan(chan_stat), .led
    );

endmodule

// ==== tests/readout_assert.sv ====
//##################################################
// Readout checks: trigger handshake, arbiter
// priority and fairness, output back-pressure
//##################################################
`timescale 1ns/1ns

module readout_assert #(
    parameter int NUM_RX = 4
) (
    input logic            bus_clk,
    input logic            rst_n,
    input logic            trigger_rj45,
    input logic            trigger_lemo,
    input logic            rj45_enabled,
    input logic            ext_veto,
    input logic            cmd_ready,
    input logic            out_ready,
    input logic            trigger_busy,
    input logic            cmd_start,
    input logic            out_write,
    input logic            trig_near_full,
    input logic [NUM_RX:0] fifo_empty,   // Trigger FIFO at index NUM_RX
    input logic [NUM_RX:0] fifo_pop
);
    int                fail_count = 0;
    logic              trig_sel;
    logic              cmd_done;      // cmd_start already seen in this handshake
    logic [NUM_RX-1:0] last_rx_pop;

    assign trig_sel = rj45_enabled ? trigger_rj45 : trigger_lemo;

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            cmd_done    <= 1'b0;
            last_rx_pop <= '0;
        end else begin
            if (!trigger_busy)
                cmd_done <= 1'b0;
            else if (cmd_start)
                cmd_done <= 1'b1;
            if (|fifo_pop[NUM_RX-1:0])
                last_rx_pop <= fifo_pop[NUM_RX-1:0];  // Trigger pops leave this alone
        end
    end

    // Accepted edge gives busy on the second clock
    busy_on_trigger: assert property (@(posedge bus_clk) disable iff (!rst_n)
        $rose(trig_sel) ##1 (!trigger_busy && !ext_veto && !trig_near_full) |=> trigger_busy)
        else begin fail_count++; $error("trigger edge did not raise trigger_busy"); end

    blocked_trigger: assert property (@(posedge bus_clk) disable iff (!rst_n)
        $rose(trig_sel) ##1 (!trigger_busy && (ext_veto || trig_near_full))
        |=> !trigger_busy && !cmd_start)
        else begin fail_count++; $error("blocked trigger started a handshake"); end

    cmd_start_due: assert property (@(posedge bus_clk) disable iff (!rst_n)
        trigger_busy && !cmd_done && !cmd_start && cmd_ready |=> cmd_start)
        else begin fail_count++; $error("cmd_ready seen but no cmd_start"); end

    cmd_start_once: assert property (@(posedge bus_clk) disable iff (!rst_n)
        cmd_start |-> trigger_busy && !cmd_done && $past(cmd_ready))
        else begin fail_count++; $error("cmd_start outside its handshake slot"); end

    trigger_first: assert property (@(posedge bus_clk) disable iff (!rst_n)
        out_ready && !fifo_empty[NUM_RX] |-> fifo_pop[NUM_RX] && fifo_pop[NUM_RX-1:0] == '0)
        else begin fail_count++; $error("pending trigger word was not served first"); end

    // Same rx channel twice only if every other rx channel is empty
    rx_fairness: assert property (@(posedge bus_clk) disable iff (!rst_n)
        (fifo_pop[NUM_RX-1:0] != '0) && (fifo_pop[NUM_RX-1:0] == last_rx_pop)
        |-> &(fifo_empty[NUM_RX-1:0] | last_rx_pop))
        else begin fail_count++; $error("rx channel granted twice while another waited"); end

    stall_output: assert property (@(posedge bus_clk) disable iff (!rst_n)
        !out_ready |-> fifo_pop == '0 ##1 !out_write)
        else begin fail_count++; $error("word moved while out_ready was low"); end

endmodule

bind readout_top readout_assert #(.NUM_RX(NUM_RX)) u_assert (.*);

// ==== tests/readout_tb.sv ====
//##################################################
// Readout core testbench with triggers, channel traffic,
// back-pressure and overflow against a word scoreboard
//##################################################
`timescale 1ns/1ns

module readout_tb;
    import readout_pkg::*;

    localparam int NUM_RX      = 4;
    localparam int FIFO_DEPTH  = 8;
    localparam int VERSION     = 3;
    localparam int RAND_CYCLES = 300;
    localparam int TEST_CYCLES = RAND_CYCLES + 500;  // Trigger, drain and overflow phases

    logic                 bus_clk;
    logic                 rst_n;
    logic                 trigger_rj45;
    logic                 trigger_lemo;
    logic                 rj45_enabled;
    logic                 ext_veto;
    logic                 cmd_ready;
    logic [NUM_RX-1:0]    rx_valid;
    logic [PAYLOAD_W-1:0] rx_payload [NUM_RX];
    logic [NUM_RX-1:0]    rx_locked;
    logic                 out_ready;
    logic                 trigger_busy;
    logic                 cmd_start;
    logic                 out_write;
    data_word_t           out_word;
    logic [NUM_RX:0]      led;

    logic [PAYLOAD_W-1:0] exp_q [16][$];   // Expected payloads per source id
    logic [PAYLOAD_W-1:0] exp_payload;
    int                   trig_count = 0;
    int                   mismatches = 0;
    int                   errors = 0;

    readout_top #(.BLINK_DIV(8), .VERSION_CYCLES(64)) dut0 (.*);

    initial begin
        bus_clk = 1'b0;
        forever #20 bus_clk = ~bus_clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("CHECK FAILED time=%0t %s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    function automatic int pending();
        int total;
        total = 0;
        foreach (exp_q[s])
            total += exp_q[s].size();
        return total;
    endfunction

    task automatic wait_idle();
        int n;
        n = 0;
        while (trigger_busy && n < 50) begin
            @(posedge bus_clk);
            n++;
        end
        if (trigger_busy) begin
            errors++;
            $display("%0t: trigger_busy stayed high after the trigger went low", $time);
        end
    endtask

    // One trigger pulse that the sequencer answers only when it should pass
    task automatic send_trigger(input logic use_rj45, input logic accepted);
        int n;
        @(posedge bus_clk);
        rj45_enabled <= use_rj45;
        @(posedge bus_clk);
        if (use_rj45)
            trigger_rj45 <= 1'b1;
        else
            trigger_lemo <= 1'b1;
        repeat (3 + $urandom_range(4)) @(posedge bus_clk);  // Sequencer still busy
        if (accepted) begin
            cmd_ready <= 1'b1;
            n = 0;
            @(posedge bus_clk);
            while (!cmd_start && n < 20) begin
                @(posedge bus_clk);
                n++;
            end
            if (!cmd_start) begin
                errors++;
                $display("%0t: no cmd_start while cmd_ready was high", $time);
            end else begin
                exp_q[TRIG_ID].push_back(PAYLOAD_W'(trig_count));
                trig_count++;
            end
            cmd_ready <= 1'b0;
        end
        trigger_rj45 <= 1'b0;
        trigger_lemo <= 1'b0;
        wait_idle();
    endtask

    task automatic drive_rx(input logic [NUM_RX-1:0] mask, input logic record);
        logic [PAYLOAD_W-1:0] pl;
        @(posedge bus_clk);
        rx_valid <= mask;
        for (int c = 0; c < NUM_RX; c++) begin
            pl = PAYLOAD_W'($urandom);
            rx_payload[c] <= pl;
            if (mask[c] && record)
                exp_q[c + 1].push_back(pl);  // Channel c carries id c+1
        end
    endtask

    task automatic drain(input int max_cycles);
        int n;
        n = 0;
        @(posedge bus_clk);
        out_ready <= 1'b1;
        rx_valid  <= '0;
        while (pending() != 0 && n < max_cycles) begin
            @(posedge bus_clk);
            n++;
        end
        repeat (3) @(posedge bus_clk);  // Room for a stray word to show up
    endtask

    // Scoreboard on the output stream
    always @(posedge bus_clk) begin
        if (rst_n && out_write) begin
            if (exp_q[out_word.src_id].size() == 0) begin
                errors++;
                $display("%0t: unexpected word %h on out_word", $time, out_word);
            end else begin
                exp_payload = exp_q[out_word.src_id].pop_front();
                check_value("out_word.payload", exp_payload, out_word.payload);
            end
        end
    end

    initial begin
        logic [NUM_RX-1:0] mask;
        void'($urandom(64453));
        rst_n        = 1'b0;
        trigger_rj45 = 1'b0;
        trigger_lemo = 1'b0;
        rj45_enabled = 1'b0;
        ext_veto     = 1'b0;
        cmd_ready    = 1'b0;
        rx_valid     = '0;
        rx_locked    = '1;
        out_ready    = 1'b1;
        foreach (rx_payload[c])
            rx_payload[c] = '0;
        repeat (3) @(posedge bus_clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge bus_clk);
        check_value("led", VERSION, led);

        for (int i = 0; i < 4; i++)
            send_trigger(i[0], 1'b1);
        @(posedge bus_clk);
        ext_veto <= 1'b1;
        send_trigger(1'b1, 1'b0);
        @(posedge bus_clk);
        ext_veto <= 1'b0;
        drain(50);

        // Trigger FIFO fills to near full behind a stalled output and the last one is refused
        @(posedge bus_clk);
        out_ready <= 1'b0;
        for (int i = 0; i < FIFO_DEPTH; i++)
            send_trigger(i[0], i < FIFO_DEPTH - 1);
        drive_rx('1, 1'b1);
        drive_rx('1, 1'b1);
        drain(100);
        send_trigger(1'b1, 1'b1);  // Number carries on from before the refused trigger

        for (int t = 0; t < RAND_CYCLES; t++) begin
            for (int c = 0; c < NUM_RX; c++)
                mask[c] = ($urandom_range(2) == 0) && (exp_q[c + 1].size() < FIFO_DEPTH - 2);
            drive_rx(mask, 1'b1);
            out_ready <= ($urandom_range(3) != 0);
        end
        drain(100);

        // Nine words into channel 0 with the output stalled so the ninth is lost
        @(posedge bus_clk);
        out_ready <= 1'b0;
        for (int i = 0; i <= FIFO_DEPTH; i++)
            drive_rx(4'b0001, i < FIFO_DEPTH);
        drive_rx('0, 1'b0);
        repeat (2) @(posedge bus_clk);
        repeat (16) begin
            @(posedge bus_clk);
            check_value("led[1]", 1, led[1]);
        end
        drain(100);

        $display("Result: mismatches=%0d missing=%0d other=%0d assertions=%0d",
                 mismatches, pending(), errors, dut0.u_assert.fail_count);
        if (mismatches + pending() + errors + dut0.u_assert.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(TEST_CYCLES * 40 * 3 / 2);
        $display("Watchdog expired, the run hung for %0d cycles", TEST_CYCLES * 3 / 2);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== readout_top.f ====
hdl/readout_pkg.sv
hdl/trigger_fsm.sv
hdl/blink_timer.sv
hdl/channel_fifo.sv
hdl/priority_arbiter.sv
hdl/led_status.sv
hdl/readout_top.sv
tests/readout_assert.sv
tests/readout_tb.sv
